// ==== alu_cfg.svh ====
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Datapath and address widths
`define XLEN          32
`define VADDR_SIZE    32

// Issue queue entries and dispatch credits
`define IQ_DEPTH      4

// Fetch stream table
`define ST_DEPTH      8
`define PRED_WIDTH    3

// Micro-op field widths
`define IMM_WIDTH     20
`define INTOP_WIDTH   4
`define BROP_WIDTH    3
`define RD_WIDTH      5
`define ROB_IDX_WIDTH 6

`endif

// ==== alu_exec_assertions.sv ====
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_exec_assertions (
    input logic                      clk,
    input logic                      arst_n,
    input logic                      iss_valid,
    input logic                      credit_return,
    input logic                      wb_valid,
    input logic                      wb_ready,
    input logic [`XLEN-1:0]          wb_data,
    input logic [`RD_WIDTH-1:0]      wb_rd,
    input logic [`ROB_IDX_WIDTH-1:0] wb_rob_idx,
    input logic                      wb_we,
    input logic                      br_valid,
    input logic                      br_taken,
    input logic [`VADDR_SIZE-1:0]    br_target,
    input logic                      br_mispredict
);
    int credits;  // Credits the sender still holds

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            credits <= `IQ_DEPTH;
        else
            credits <= credits + int'(credit_return) - int'(iss_valid);
    end

    a_issue_credit: assert property (@(posedge clk) disable iff (!arst_n)
        iss_valid |-> credits > 0)
        else $error("issue made with no credit left");

    a_wb_hold: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb_data) && $stable(wb_rd) &&
            $stable(wb_rob_idx) && $stable(wb_we) && $stable(br_valid) &&
            $stable(br_taken) && $stable(br_target) && $stable(br_mispredict))
        else $error("writeback output changed while stalled");

    // A credit never comes back for an entry that was not issued since reset
    a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
        credits <= `IQ_DEPTH)
        else $error("more credits returned than micro-ops issued");

endmodule

bind alu_exec_top alu_exec_assertions u_assertions (
    .clk, .arst_n, .iss_valid, .credit_return, .wb_valid, .wb_ready, .wb_data, .wb_rd,
    .wb_rob_idx, .wb_we, .br_valid, .br_taken, .br_target, .br_mispredict
);

// ==== alu_exec_top.sv ====
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_exec_top (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      iss_valid,
    input  exec_pkg::uop_class_e      iss_class,
    input  exec_pkg::int_op_e         iss_int_op,
    input  branch_pkg::branch_op_e    iss_br_op,
    input  exec_pkg::imm_u            iss_imm,
    input  logic                      iss_immv,
    input  logic                      iss_uext,
    input  logic [`XLEN-1:0]          iss_rs1,
    input  logic [`XLEN-1:0]          iss_rs2,
    input  branch_pkg::stream_idx_t   iss_stream_idx,
    input  branch_pkg::pred_off_t     iss_offset,
    input  logic [`RD_WIDTH-1:0]      iss_rd,
    input  logic [`ROB_IDX_WIDTH-1:0] iss_rob_idx,
    input  logic                      iss_we,
    output logic                      credit_return,
    input  logic                      st_we,
    input  branch_pkg::stream_idx_t   st_idx,
    input  logic [`VADDR_SIZE-1:0]    st_start_addr,
    input  branch_pkg::pred_off_t     st_size,
    input  logic                      st_taken,
    input  logic [`VADDR_SIZE-1:0]    st_target,
    output logic                      wb_valid,
    input  logic                      wb_ready,
    output logic [`XLEN-1:0]          wb_data,
    output logic [`RD_WIDTH-1:0]      wb_rd,
    output logic [`ROB_IDX_WIDTH-1:0] wb_rob_idx,
    output logic                      wb_we,
    output logic                      br_valid,
    output logic                      br_taken,
    output logic [`VADDR_SIZE-1:0]    br_target,
    output logic                      br_mispredict
);
    import exec_pkg::*;
    import branch_pkg::*;

    logic                      head_valid, head_immv, head_uext, head_we, pop;
    uop_class_e                head_class;
    int_op_e                   head_int_op;
    branch_op_e                head_br_op;
    imm_u                      head_imm;
    logic [`XLEN-1:0]          head_rs1, head_rs2, alu_result;
    stream_idx_t               head_stream_idx;
    pred_off_t                 head_offset, rd_size;
    logic [`RD_WIDTH-1:0]      head_rd;
    logic [`ROB_IDX_WIDTH-1:0] head_rob_idx;
    logic [`VADDR_SIZE-1:0]    rd_start_addr, rd_target, bu_target, bu_link;
    logic                      rd_taken, bu_taken, bu_mispredict;

    alu_issue_queue u_iq (
        .clk, .arst_n,
        .push(iss_valid), .push_class(iss_class), .push_int_op(iss_int_op),
        .push_br_op(iss_br_op), .push_imm(iss_imm), .push_immv(iss_immv),
        .push_uext(iss_uext), .push_rs1(iss_rs1), .push_rs2(iss_rs2),
        .push_stream_idx(iss_stream_idx), .push_offset(iss_offset), .push_rd(iss_rd),
        .push_rob_idx(iss_rob_idx), .push_we(iss_we), .pop,
        .head_valid, .head_class, .head_int_op, .head_br_op, .head_imm, .head_immv,
        .head_uext, .head_rs1, .head_rs2, .head_stream_idx, .head_offset, .head_rd,
        .head_rob_idx, .head_we, .credit_return
    );

    fetch_stream_table u_fst (
        .clk, .arst_n, .we(st_we), .wr_idx(st_idx), .wr_start_addr(st_start_addr),
        .wr_size(st_size), .wr_taken(st_taken), .wr_target(st_target),
        .rd_idx(head_stream_idx), .rd_start_addr, .rd_size, .rd_taken, .rd_target
    );

    int_alu u_alu (
        .int_op(head_int_op), .imm(head_imm), .immv(head_immv), .uext(head_uext),
        .rs1(head_rs1), .rs2(head_rs2), .start_addr(rd_start_addr),
        .offset(head_offset), .result(alu_result)
    );

    branch_unit u_bru (
        .br_op(head_br_op), .imm(head_imm), .uext(head_uext), .rs1(head_rs1),
        .rs2(head_rs2), .offset(head_offset), .start_addr(rd_start_addr),
        .size(rd_size), .taken(rd_taken), .pred_target(rd_target),
        .taken_o(bu_taken), .target(bu_target), .mispredict(bu_mispredict), .link(bu_link)
    );

    // Output register takes a new entry when empty or being drained this cycle
    assign pop = head_valid & (~wb_valid | wb_ready);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
            br_valid <= 1'b0;
        end else if (pop) begin
            wb_valid <= 1'b1;
            br_valid <= (head_class == UOP_BR);
        end else if (wb_ready) begin
            wb_valid <= 1'b0;
            br_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            wb_data       <= (head_class == UOP_BR) ? bu_link : alu_result;
            wb_rd         <= head_rd;
            wb_rob_idx    <= head_rob_idx;
            wb_we         <= head_we;
            br_taken      <= bu_taken;
            br_target     <= bu_target;
            br_mispredict <= bu_mispredict;
        end
    end

endmodule

// ==== alu_issue_queue.sv ====
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_issue_queue (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      push,
    input  exec_pkg::uop_class_e      push_class,
    input  exec_pkg::int_op_e         push_int_op,
    input  branch_pkg::branch_op_e    push_br_op,
    input  exec_pkg::imm_u            push_imm,
    input  logic                      push_immv,
    input  logic                      push_uext,
    input  logic [`XLEN-1:0]          push_rs1,
    input  logic [`XLEN-1:0]          push_rs2,
    input  branch_pkg::stream_idx_t   push_stream_idx,
    input  branch_pkg::pred_off_t     push_offset,
    input  logic [`RD_WIDTH-1:0]      push_rd,
    input  logic [`ROB_IDX_WIDTH-1:0] push_rob_idx,
    input  logic                      push_we,
    input  logic                      pop,
    output logic                      head_valid,
    output exec_pkg::uop_class_e      head_class,
    output exec_pkg::int_op_e         head_int_op,
    output branch_pkg::branch_op_e    head_br_op,
    output exec_pkg::imm_u            head_imm,
    output logic                      head_immv,
    output logic                      head_uext,
    output logic [`XLEN-1:0]          head_rs1,
    output logic [`XLEN-1:0]          head_rs2,
    output branch_pkg::stream_idx_t   head_stream_idx,
    output branch_pkg::pred_off_t     head_offset,
    output logic [`RD_WIDTH-1:0]      head_rd,
    output logic [`ROB_IDX_WIDTH-1:0] head_rob_idx,
    output logic                      head_we,
    output logic                      credit_return
);
    import exec_pkg::*;
    import branch_pkg::*;

    localparam int PTR_W = $clog2(`IQ_DEPTH);
    localparam int CNT_W = $clog2(`IQ_DEPTH + 1);

    uop_class_e               cls_q    [`IQ_DEPTH];
    int_op_e                  int_op_q [`IQ_DEPTH];
    branch_op_e               br_op_q  [`IQ_DEPTH];
    imm_u                     imm_q    [`IQ_DEPTH];
    logic                     immv_q   [`IQ_DEPTH];
    logic                     uext_q   [`IQ_DEPTH];
    logic [`XLEN-1:0]         rs1_q    [`IQ_DEPTH];
    logic [`XLEN-1:0]         rs2_q    [`IQ_DEPTH];
    stream_idx_t              sidx_q   [`IQ_DEPTH];
    pred_off_t                off_q    [`IQ_DEPTH];
    logic [`RD_WIDTH-1:0]     rd_q     [`IQ_DEPTH];
    logic [`ROB_IDX_WIDTH-1:0] rob_q   [`IQ_DEPTH];
    logic                     we_q     [`IQ_DEPTH];

    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(`IQ_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit_return <= pop;  // One credit back per entry leaving
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            cls_q[wr_ptr]    <= push_class;
            int_op_q[wr_ptr] <= push_int_op;
            br_op_q[wr_ptr]  <= push_br_op;
            imm_q[wr_ptr]    <= push_imm;
            immv_q[wr_ptr]   <= push_immv;
            uext_q[wr_ptr]   <= push_uext;
            rs1_q[wr_ptr]    <= push_rs1;
            rs2_q[wr_ptr]    <= push_rs2;
            sidx_q[wr_ptr]   <= push_stream_idx;
            off_q[wr_ptr]    <= push_offset;
            rd_q[wr_ptr]     <= push_rd;
            rob_q[wr_ptr]    <= push_rob_idx;
            we_q[wr_ptr]     <= push_we;
        end
    end

    assign head_valid      = (count != '0);
    assign head_class      = cls_q[rd_ptr];
    assign head_int_op     = int_op_q[rd_ptr];
    assign head_br_op      = br_op_q[rd_ptr];
    assign head_imm        = imm_q[rd_ptr];
    assign head_immv       = immv_q[rd_ptr];
    assign head_uext       = uext_q[rd_ptr];
    assign head_rs1        = rs1_q[rd_ptr];
    assign head_rs2        = rs2_q[rd_ptr];
    assign head_stream_idx = sidx_q[rd_ptr];
    assign head_offset     = off_q[rd_ptr];
    assign head_rd         = rd_q[rd_ptr];
    assign head_rob_idx    = rob_q[rd_ptr];
    assign head_we         = we_q[rd_ptr];

endmodule

// ==== branch_pkg.sv ====
`include "alu_cfg.svh"

package branch_pkg;

    typedef enum logic [`BROP_WIDTH-1:0] {
        BR_BEQ  = 3'd0,
        BR_BNE  = 3'd1,
        BR_BLT  = 3'd2,  // BLTU when uext is set
        BR_BGE  = 3'd3,  // BGEU when uext is set
        BR_JAL  = 3'd4,
        BR_JALR = 3'd5
    } branch_op_e;

    // Entry index into the fetch stream table
    typedef logic [$clog2(`ST_DEPTH)-1:0] stream_idx_t;

    // Instruction slot within a fetch stream
    typedef logic [`PRED_WIDTH-1:0] pred_off_t;

endpackage

// ==== branch_unit.sv ====
`timescale 1ns/1ps
`include "alu_cfg.svh"

module branch_unit (
    input  branch_pkg::branch_op_e  br_op,
    input  exec_pkg::imm_u          imm,
    input  logic                    uext,
    input  logic [`XLEN-1:0]        rs1,
    input  logic [`XLEN-1:0]        rs2,
    input  branch_pkg::pred_off_t   offset,
    input  logic [`VADDR_SIZE-1:0]  start_addr,
    input  branch_pkg::pred_off_t   size,
    input  logic                    taken,
    input  logic [`VADDR_SIZE-1:0]  pred_target,
    output logic                    taken_o,
    output logic [`VADDR_SIZE-1:0]  target,
    output logic                    mispredict,
    output logic [`VADDR_SIZE-1:0]  link
);
    import branch_pkg::*;

    logic [`XLEN-1:0]        s_imm;
    logic [`PRED_WIDTH:0]    next_off;
    logic [`VADDR_SIZE-1:0]  pc_off, link_off;
    logic [`VADDR_SIZE-1:0]  br_target, jalr_target;
    logic                    equal, lt, dir;
    logic                    hit, cond_err, jalr_err;

    // Branch offsets are always even
    assign s_imm = {{(`XLEN-12){imm.i_view.imm12[11]}}, imm.i_view.imm12[11:1], 1'b0};

    assign equal = rs1 == rs2;
    assign lt    = uext ? (rs1 < rs2) : ($signed(rs1) < $signed(rs2));

    always_comb begin
        case (br_op)
            BR_BEQ:  dir = equal;
            BR_BNE:  dir = ~equal;
            BR_BLT:  dir = lt;
            BR_BGE:  dir = ~lt;
            BR_JAL,
            BR_JALR: dir = 1'b1;
            default: dir = 1'b0;
        endcase
    end

    assign pc_off   = {{(`VADDR_SIZE-`PRED_WIDTH-2){1'b0}}, offset, 2'b00};
    assign next_off = {1'b0, offset} + 1'b1;
    assign link_off = {{(`VADDR_SIZE-`PRED_WIDTH-3){1'b0}}, next_off, 2'b00};

    assign br_target   = start_addr + pc_off + s_imm;
    assign jalr_target = rs1 + s_imm;
    assign link        = start_addr + link_off;  // Also the fall-through address

    assign taken_o = dir;
    assign target  = (br_op == BR_JALR) ? jalr_target :
                     dir                ? br_target   : link;

    // Predicted stream ends exactly at this instruction
    assign hit      = size == offset;
    assign cond_err = hit ? (taken ^ dir) | (taken & (pred_target != br_target)) : dir;
    assign jalr_err = ~hit | (pred_target != jalr_target);

    always_comb begin
        case (br_op)
            BR_JALR: mispredict = jalr_err;
            BR_JAL:  mispredict = 1'b0;
            default: mispredict = cond_err;
        endcase
    end

endmodule

// ==== build.f ====
+incdir+.
exec_pkg.sv
branch_pkg.sv
alu_issue_queue.sv
int_alu.sv
branch_unit.sv
fetch_stream_table.sv
alu_exec_top.sv
alu_exec_assertions.sv
tb_alu_exec.sv

// ==== exec_pkg.sv ====
`include "alu_cfg.svh"

package exec_pkg;

    typedef enum logic [`INTOP_WIDTH-1:0] {
        INT_ADD   = 4'd0,
        INT_SUB   = 4'd1,
        INT_LUI   = 4'd2,
        INT_SLT   = 4'd3,  // SLTU when uext is set
        INT_OR    = 4'd4,
        INT_XOR   = 4'd5,
        INT_AND   = 4'd6,
        INT_SL    = 4'd7,
        INT_SR    = 4'd8,  // SRL when uext is set, SRA otherwise
        INT_AUIPC = 4'd9
    } int_op_e;

    // Which result goes to writeback
    typedef enum logic {
        UOP_INT = 1'b0,
        UOP_BR  = 1'b1
    } uop_class_e;

    // Immediate field decoded as I/B-type or as U-type
    typedef union packed {
        struct packed {
            logic [`IMM_WIDTH-13:0] unused;
            logic [11:0]            imm12;
        } i_view;
        logic [`IMM_WIDTH-1:0] u_view;
    } imm_u;

endpackage

// ==== fetch_stream_table.sv ====
`timescale 1ns/1ps
`include "alu_cfg.svh"

module fetch_stream_table (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    we,
    input  branch_pkg::stream_idx_t wr_idx,
    input  logic [`VADDR_SIZE-1:0]  wr_start_addr,
    input  branch_pkg::pred_off_t   wr_size,
    input  logic                    wr_taken,
    input  logic [`VADDR_SIZE-1:0]  wr_target,
    input  branch_pkg::stream_idx_t rd_idx,
    output logic [`VADDR_SIZE-1:0]  rd_start_addr,
    output branch_pkg::pred_off_t   rd_size,
    output logic                    rd_taken,
    output logic [`VADDR_SIZE-1:0]  rd_target
);
    import branch_pkg::*;

    logic [`VADDR_SIZE-1:0] start_q  [`ST_DEPTH];
    pred_off_t              size_q   [`ST_DEPTH];
    logic                   taken_q  [`ST_DEPTH];
    logic [`VADDR_SIZE-1:0] target_q [`ST_DEPTH];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `ST_DEPTH; i++) begin
                start_q[i]  <= '0;
                size_q[i]   <= '0;
                taken_q[i]  <= 1'b0;
                target_q[i] <= '0;
            end
        end else if (we) begin
            start_q[wr_idx]  <= wr_start_addr;
            size_q[wr_idx]   <= wr_size;
            taken_q[wr_idx]  <= wr_taken;
            target_q[wr_idx] <= wr_target;
        end
    end

    // Combinational read for the branch unit and AUIPC
    assign rd_start_addr = start_q[rd_idx];
    assign rd_size       = size_q[rd_idx];
    assign rd_taken      = taken_q[rd_idx];
    assign rd_target     = target_q[rd_idx];

endmodule

// ==== int_alu.sv ====
`timescale 1ns/1ps
`include "alu_cfg.svh"

module int_alu (
    input  exec_pkg::int_op_e       int_op,
    input  exec_pkg::imm_u          imm,
    input  logic                    immv,
    input  logic                    uext,
    input  logic [`XLEN-1:0]        rs1,
    input  logic [`XLEN-1:0]        rs2,
    input  logic [`VADDR_SIZE-1:0]  start_addr,
    input  branch_pkg::pred_off_t   offset,
    output logic [`XLEN-1:0]        result
);
    import exec_pkg::*;

    localparam int SH_W = $clog2(`XLEN);

    logic [`XLEN-1:0]       lui_imm, s_imm, op2;
    logic [`VADDR_SIZE-1:0] pc_off;
    logic [SH_W-1:0]        shamt;
    logic                   ult, slt, lt;
    logic                   pad;
    logic [`XLEN-1:0]       sr_data;

    assign lui_imm = {imm.u_view, 12'b0};
    assign s_imm   = {{(`XLEN-12){imm.i_view.imm12[11]}}, imm.i_view.imm12};
    assign op2     = immv ? s_imm : rs2;
    assign pc_off  = {{(`VADDR_SIZE-`PRED_WIDTH-2){1'b0}}, offset, 2'b00};  // Slot * 4

    // Signed less-than from the unsigned compare and the two sign bits
    assign ult = rs1 < op2;
    always_comb begin
        case ({rs1[`XLEN-1], op2[`XLEN-1]})
            2'b01:   slt = 1'b0;
            2'b10:   slt = 1'b1;
            default: slt = ult;
        endcase
    end
    assign lt = uext ? ult : slt;

    assign shamt = op2[SH_W-1:0];
    assign pad   = rs1[`XLEN-1] & ~uext;  // Logical shift when uext

    // Right barrel shifter with one case per shift amount
    always_comb begin
        sr_data = rs1;
        for (int s = 1; s < `XLEN; s++) begin
            if (shamt == SH_W'(s)) begin
                sr_data = (rs1 >> s) | ({`XLEN{pad}} << (`XLEN - s));
            end
        end
    end

    always_comb begin
        case (int_op)
            INT_ADD:   result = rs1 + op2;
            INT_SUB:   result = rs1 - rs2;  // Register form only
            INT_LUI:   result = lui_imm;
            INT_SLT:   result = {{(`XLEN-1){1'b0}}, lt};
            INT_OR:    result = rs1 | op2;
            INT_XOR:   result = rs1 ^ op2;
            INT_AND:   result = rs1 & op2;
            INT_SL:    result = rs1 << shamt;
            INT_SR:    result = sr_data;
            INT_AUIPC: result = start_addr + pc_off + lui_imm;
            default:   result = '0;
        endcase
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

TOP=tb_alu_exec
LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal --top-module "$TOP" -f build.f -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test FAILED" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if ! grep -q "Test OK" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

// ==== tb_alu_exec.sv ====
`timescale 1ns/1ps
`include "alu_cfg.svh"

module tb_alu_exec;
    import exec_pkg::*;
    import branch_pkg::*;

    localparam int NUM_UOPS = 300;
    localparam int FILL     = `IQ_DEPTH + 1;  // Queue entries plus the held output register
    localparam int BUDGET   = 20 * (NUM_UOPS + FILL + `ST_DEPTH + 4);

    typedef struct packed {
        logic [`XLEN-1:0]          data;
        logic [`RD_WIDTH-1:0]      rd;
        logic [`ROB_IDX_WIDTH-1:0] rob;
        logic                      we;
        logic                      brv;
        logic                      taken;
        logic [`VADDR_SIZE-1:0]    target;
        logic                      misp;
    } wb_exp_t;

    logic                      clk, arst_n;
    logic                      iss_valid, iss_immv, iss_uext, iss_we;
    uop_class_e                iss_class;
    int_op_e                   iss_int_op;
    branch_op_e                iss_br_op;
    imm_u                      iss_imm;
    logic [`XLEN-1:0]          iss_rs1, iss_rs2, wb_data;
    stream_idx_t               iss_stream_idx, st_idx;
    pred_off_t                 iss_offset, st_size;
    logic [`RD_WIDTH-1:0]      iss_rd, wb_rd;
    logic [`ROB_IDX_WIDTH-1:0] iss_rob_idx, wb_rob_idx;
    logic                      credit_return, st_we, st_taken, wb_ready, wb_valid, wb_we;
    logic [`VADDR_SIZE-1:0]    st_start_addr, st_target, br_target;
    logic                      br_valid, br_taken, br_mispredict;

    // Stream table copy; delta is the even branch offset that lands on the predicted target
    logic [`VADDR_SIZE-1:0] tst_start  [`ST_DEPTH];
    logic [`VADDR_SIZE-1:0] tst_target [`ST_DEPTH];
    pred_off_t              tst_size   [`ST_DEPTH];
    logic                   tst_taken  [`ST_DEPTH];
    logic [11:0]            tst_delta  [`ST_DEPTH];

    logic [31:0] lfsr = 32'd85;
    int          credits, issued, returned, wb_count;
    wb_exp_t     exp_q [$];

    alu_exec_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic wb_exp_t ref_exec(input uop_class_e cls, input int_op_e iop,
            input branch_op_e bop, input imm_u imm, input logic immv, input logic uext,
            input logic [31:0] rs1, input logic [31:0] rs2, input stream_idx_t idx,
            input pred_off_t off);
        wb_exp_t            e;
        logic [31:0]        pc, link, op2, simm, btgt, alu;
        logic signed [31:0] sra;
        logic               lt, blt, hit;
        e    = '0;
        pc   = tst_start[idx] + 32'(off) * 4;
        link = pc + 4;
        op2  = immv ? 32'($signed(imm.i_view.imm12)) : rs2;
        lt   = uext ? (rs1 < op2) : ($signed(rs1) < $signed(op2));
        sra  = $signed(rs1) >>> op2[4:0];
        case (iop)
            INT_ADD:   alu = rs1 + op2;
            INT_SUB:   alu = rs1 - rs2;
            INT_LUI:   alu = {imm.u_view, 12'h000};
            INT_SLT:   alu = 32'(lt);
            INT_OR:    alu = rs1 | op2;
            INT_XOR:   alu = rs1 ^ op2;
            INT_AND:   alu = rs1 & op2;
            INT_SL:    alu = rs1 << op2[4:0];
            INT_SR:    alu = uext ? (rs1 >> op2[4:0]) : sra;
            INT_AUIPC: alu = pc + {imm.u_view, 12'h000};
            default:   alu = '0;
        endcase
        simm = 32'($signed({imm.i_view.imm12[11:1], 1'b0}));
        btgt = pc + simm;
        hit  = tst_size[idx] == off;
        blt  = uext ? (rs1 < rs2) : ($signed(rs1) < $signed(rs2));
        case (bop)
            BR_BEQ:  e.taken = rs1 == rs2;
            BR_BNE:  e.taken = rs1 != rs2;
            BR_BLT:  e.taken = blt;
            BR_BGE:  e.taken = !blt;
            default: e.taken = 1'b1;  // JAL, JALR
        endcase
        if (bop == BR_JALR) begin
            e.target = rs1 + simm;
            e.misp   = !hit || (tst_target[idx] != e.target);
        end else if (bop == BR_JAL) begin
            e.target = btgt;
            e.misp   = 1'b0;
        end else begin
            e.target = e.taken ? btgt : link;
            if (hit)
                e.misp = (tst_taken[idx] != e.taken) ||
                         (tst_taken[idx] && (tst_target[idx] != btgt));
            else
                e.misp = e.taken;
        end
        e.brv  = cls == UOP_BR;
        e.data = e.brv ? link : alu;
        return e;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_wb(input logic [`XLEN-1:0] data, input logic [`RD_WIDTH-1:0] rd,
            input logic [`ROB_IDX_WIDTH-1:0] rob, input logic we);
        if (wb_data !== data)
            fail_run($sformatf("mismatch wb_data: expected %h, got %h", data, wb_data));
        else if (wb_rd !== rd)
            fail_run($sformatf("mismatch wb_rd: expected %h, got %h", rd, wb_rd));
        else if (wb_rob_idx !== rob)
            fail_run($sformatf("mismatch wb_rob_idx: expected %h, got %h", rob, wb_rob_idx));
        else if (wb_we !== we)
            fail_run($sformatf("mismatch wb_we: expected %h, got %h", we, wb_we));
    endtask

    task automatic check_branch(input logic valid, input logic taken,
            input logic [`VADDR_SIZE-1:0] target, input logic misp);
        if (br_valid !== valid)
            fail_run($sformatf("mismatch br_valid: expected %h, got %h", valid, br_valid));
        else if (valid && br_taken !== taken)
            fail_run($sformatf("mismatch br_taken: expected %h, got %h", taken, br_taken));
        else if (valid && br_target !== target)
            fail_run($sformatf("mismatch br_target: expected %h, got %h", target, br_target));
        else if (valid && br_mispredict !== misp)
            fail_run($sformatf("mismatch br_mispredict: expected %h, got %h", misp,
                               br_mispredict));
    endtask

    // One clock; collects returned credits and drops the one-cycle strobes
    task automatic tick();
        @(posedge clk);
        if (credit_return) begin
            credits++;
            returned++;
        end
        iss_valid <= 1'b0;
        st_we     <= 1'b0;
    endtask

    task automatic issue_uop();
        uop_class_e  cls;
        int_op_e     iop;
        branch_op_e  bop;
        imm_u        imm;
        logic        immv, uext;
        logic [31:0] rs1, rs2;
        stream_idx_t idx;
        pred_off_t   off;
        wb_exp_t     e;
        cls  = uop_class_e'(rand_bits(1) != 0);
        iop  = int_op_e'(4'(rand_bits(4) % 10));
        bop  = branch_op_e'(3'(rand_bits(3) % 6));
        imm  = imm_u'(20'(rand_bits(20)));
        immv = rand_bits(1) != 0;
        uext = rand_bits(1) != 0;
        rs1  = rand_bits(32);
        rs2  = (rand_bits(2) == 0) ? rs1 : rand_bits(32);
        idx  = stream_idx_t'(rand_bits(3));
        off  = (rand_bits(1) != 0) ? tst_size[idx] : pred_off_t'(rand_bits(3));
        if (rand_bits(1) != 0) begin  // Aim at the predicted target
            imm.i_view.imm12 = tst_delta[idx];
            if (bop == BR_JALR)
                rs1 = tst_target[idx] - 32'($signed(tst_delta[idx]));
        end
        e     = ref_exec(cls, iop, bop, imm, immv, uext, rs1, rs2, idx, off);
        e.rd  = 5'(rand_bits(5));
        e.rob = 6'(issued);
        e.we  = rand_bits(1) != 0;
        exp_q.push_back(e);
        iss_valid      <= 1'b1;
        iss_class      <= cls;
        iss_int_op     <= iop;
        iss_br_op      <= bop;
        iss_imm        <= imm;
        iss_immv       <= immv;
        iss_uext       <= uext;
        iss_rs1        <= rs1;
        iss_rs2        <= rs2;
        iss_stream_idx <= idx;
        iss_offset     <= off;
        iss_rd         <= e.rd;
        iss_rob_idx    <= e.rob;
        iss_we         <= e.we;
        credits--;
        issued++;
    endtask

    initial begin
        credits        = `IQ_DEPTH;
        issued         = 0;
        returned       = 0;
        wb_count       = 0;
        arst_n         = 1'b0;
        iss_valid      = 1'b0;
        iss_class      = UOP_INT;
        iss_int_op     = INT_ADD;
        iss_br_op      = BR_BEQ;
        iss_imm        = '0;
        iss_immv       = 1'b0;
        iss_uext       = 1'b0;
        iss_rs1        = '0;
        iss_rs2        = '0;
        iss_stream_idx = '0;
        iss_offset     = '0;
        iss_rd         = '0;
        iss_rob_idx    = '0;
        iss_we         = 1'b0;
        st_we          = 1'b0;
        st_idx         = '0;
        st_start_addr  = '0;
        st_size        = '0;
        st_taken       = 1'b0;
        st_target      = '0;
        wb_ready       = 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < `ST_DEPTH; i++) begin
            tick();
            tst_start[i]  = rand_bits(32) & ~32'h3;
            tst_size[i]   = pred_off_t'(rand_bits(3));
            tst_taken[i]  = rand_bits(1) != 0;
            tst_delta[i]  = 12'(rand_bits(12)) & 12'hffe;
            tst_target[i] = tst_start[i] + 32'(tst_size[i]) * 4 + 32'($signed(tst_delta[i]));
            st_we         <= 1'b1;
            st_idx        <= stream_idx_t'(i);
            st_start_addr <= tst_start[i];
            st_size       <= tst_size[i];
            st_taken      <= tst_taken[i];
            st_target     <= tst_target[i];
        end
        // wb_ready still low, so the sender fills the queue and then stalls
        repeat (4 * FILL) begin
            tick();
            if (credits > 0)
                issue_uop();
        end
        if (issued != FILL || credits != 0)
            fail_run($sformatf("stalled port took %0d issues with %0d credits left, wanted %0d",
                               issued, credits, FILL));
        while (issued < NUM_UOPS) begin
            tick();
            wb_ready <= rand_bits(2) != 0;
            if (credits > 0 && rand_bits(2) != 0)
                issue_uop();
        end
        while (returned < issued || wb_count < issued) begin
            tick();
            wb_ready <= 1'b1;
        end
        repeat (5) tick();
        if (returned != issued || wb_count != issued || exp_q.size() != 0)
            fail_run($sformatf("counts differ: %0d issued, %0d credits back, %0d written back",
                               issued, returned, wb_count));
        $display("Test OK");
        $finish;
    end

    initial begin
        wb_exp_t e;
        forever begin
            @(posedge clk);
            if (arst_n && wb_valid && wb_ready) begin
                if (exp_q.size() == 0) begin
                    fail_run("a writeback arrived with no micro-op outstanding");
                end else begin
                    e = exp_q.pop_front();
                    check_wb(e.data, e.rd, e.rob, e.we);
                    check_branch(e.brv, e.taken, e.target, e.misp);
                    wb_count++;
                end
            end
        end
    end

    initial begin
        repeat (BUDGET) @(posedge clk);
        $display("timeout: writeback stream not finished after %0d cycles", BUDGET);
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule
